/* test/xc_stimulus.txt */
# B rx_port data(hex) keep(hex) last idle_cycles_after expected_egress_port
# P ready_mode (0 tready high, 1 random tready, 2 tx1 tready low)
# E expected drop count rise on tx0 and tx1 over the last phase
P 0
B 0 a000000000000001 ff 0 0 1
B 1 b000000000000001 ff 0 1 0
B 0 a000000000000002 ff 0 0 1
B 0 a000000000000003 0f 1 2 1
B 1 b000000000000002 ff 0 0 0
B 1 b000000000000003 03 1 1 0
B 0 a000000000000004 ff 1 0 1
B 1 b000000000000004 01 1 3 0
P 1
B 0 c000000000000001 ff 0 1 1
B 1 d000000000000001 ff 0 2 0
B 0 c000000000000002 ff 0 1 1
B 0 c000000000000003 ff 1 3 1
B 1 d000000000000002 3f 0 1 0
B 1 d000000000000003 ff 1 2 0
B 0 c000000000000004 ff 0 1 1
B 1 d000000000000004 ff 0 1 0
B 0 c000000000000005 07 1 2 1
B 1 d000000000000005 ff 0 3 0
B 0 c000000000000006 ff 0 1 1
B 1 d000000000000006 1f 1 1 0
B 0 c000000000000007 ff 1 2 1
B 1 d000000000000007 ff 1 2 0
P 2
B 0 e000000000000001 ff 0 0 1
B 0 e000000000000002 ff 0 0 1
B 0 e000000000000003 ff 0 0 1
B 0 e000000000000004 ff 0 0 1
B 0 e000000000000005 ff 0 0 1
B 0 e000000000000006 ff 0 0 1
B 0 e000000000000007 ff 0 0 1
B 0 e000000000000008 ff 0 0 1
B 0 e000000000000009 ff 0 0 1
B 0 e00000000000000a ff 0 0 1
B 0 e00000000000000b ff 0 0 1
B 0 e00000000000000c 0f 1 0 1
E 0 4

/* flist.f */
+incdir+include
logic/eth_xc_pkg.sv
logic/axis_beat_if.sv
logic/latency_ctrl.sv
logic/sample_ring.sv
logic/delay_path.sv
logic/eth_xconnect.sv
test/tb_eth_xconnect.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_eth_xconnect \
	&& ./obj_dir/Vtb_eth_xconnect > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* test/tb_eth_xconnect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_xc_config.svh"

module tb_eth_xconnect;

	localparam int active_timeout = 100;
	localparam int drain_timeout  = 400;

	// one beat the scoreboard waits for
	typedef struct packed {
		logic [31:0]            sent_cyc;
		logic [`ETH_DATA_W-1:0] data;
		logic [`ETH_KEEP_W-1:0] keep;
		logic                   last;
	} exp_t;

	logic                   clk156 = 1'b0;
	logic                   eth_rst;
	logic                   rx0_tvalid;
	logic [`ETH_DATA_W-1:0] rx0_tdata;
	logic [`ETH_KEEP_W-1:0] rx0_tkeep;
	logic                   rx0_tlast;
	logic                   tx0_tvalid;
	logic                   tx0_tready;
	logic [`ETH_DATA_W-1:0] tx0_tdata;
	logic [`ETH_KEEP_W-1:0] tx0_tkeep;
	logic                   tx0_tlast;
	logic [`ETH_DROP_W-1:0] drop0_count;
	logic                   rx1_tvalid;
	logic [`ETH_DATA_W-1:0] rx1_tdata;
	logic [`ETH_KEEP_W-1:0] rx1_tkeep;
	logic                   rx1_tlast;
	logic                   tx1_tvalid;
	logic                   tx1_tready;
	logic [`ETH_DATA_W-1:0] tx1_tdata;
	logic [`ETH_KEEP_W-1:0] tx1_tkeep;
	logic                   tx1_tlast;
	logic [`ETH_DROP_W-1:0] drop1_count;
	logic                   delay_active;

	int          cyc = 0;
	int          err_value = 0;
	int          err_other = 0;
	int          phase_mode = 0; // 1 allows gaps in the delivered order
	int          ready_mode = 0; // 0 high, 1 random, 2 tx1 held low
	bit          run_aborted = 1'b0;
	logic [31:0] rng = 32'h098f_24c4;
	exp_t        q0 [$];
	exp_t        q1 [$];
	int          sent [2];
	int          delivered [2];
	int          gaps [2];
	int          drop_base [2];
	int          last_rise [2];

	eth_xconnect uut (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx0_tvalid  (rx0_tvalid),
		.rx0_tdata   (rx0_tdata),
		.rx0_tkeep   (rx0_tkeep),
		.rx0_tlast   (rx0_tlast),
		.tx0_tvalid  (tx0_tvalid),
		.tx0_tready  (tx0_tready),
		.tx0_tdata   (tx0_tdata),
		.tx0_tkeep   (tx0_tkeep),
		.tx0_tlast   (tx0_tlast),
		.drop0_count (drop0_count),
		.rx1_tvalid  (rx1_tvalid),
		.rx1_tdata   (rx1_tdata),
		.rx1_tkeep   (rx1_tkeep),
		.rx1_tlast   (rx1_tlast),
		.tx1_tvalid  (tx1_tvalid),
		.tx1_tready  (tx1_tready),
		.tx1_tdata   (tx1_tdata),
		.tx1_tkeep   (tx1_tkeep),
		.tx1_tlast   (tx1_tlast),
		.drop1_count (drop1_count),
		.delay_active(delay_active)
	);

	always #4 clk156 = ~clk156;

	always @(posedge clk156) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int pending_count(input int p);
		return (p == 0) ? q0.size() : q1.size();
	endfunction

	function automatic exp_t oldest_expected(input int p);
		return (p == 0) ? q0[0] : q1[0];
	endfunction

	function automatic exp_t take_expected(input int p);
		if (p == 0)
			return q0.pop_front();
		return q1.pop_front();
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expv,
		input logic [63:0] actv);
		assert (expv === actv) else begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expv, actv);
			err_value++;
		end
	endtask

	task automatic final_report();
		$display("error counts: %0d wrong values, %0d other failures",
			err_value, err_other);
		if (err_value + err_other == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		err_other++;
		run_aborted = 1'b1;
	endtask

	// one clock, then drive inputs just after the edge
	task automatic step();
		@(posedge clk156);
		#1;
		rx0_tvalid = 1'b0;
		rx1_tvalid = 1'b0;
		case (ready_mode)
			1: begin
				rng = xorshift32(rng);
				tx0_tready = rng[3];
				tx1_tready = rng[11];
			end
			2: begin
				tx0_tready = 1'b1;
				tx1_tready = 1'b0;
			end
			default: begin
				tx0_tready = 1'b1;
				tx1_tready = 1'b1;
			end
		endcase
	endtask

	task automatic send_beat(input int p, input logic [63:0] d, input logic [7:0] k,
		input logic l, input int eg);
		exp_t e;
		step();
		if (p == 0) begin
			rx0_tvalid = 1'b1;
			rx0_tdata  = d;
			rx0_tkeep  = k;
			rx0_tlast  = l;
		end else begin
			rx1_tvalid = 1'b1;
			rx1_tdata  = d;
			rx1_tkeep  = k;
			rx1_tlast  = l;
		end
		e.sent_cyc = 32'(cyc + 1); // sampled at the next edge
		e.data     = d;
		e.keep     = k;
		e.last     = l;
		if (eg == 0)
			q0.push_back(e);
		else
			q1.push_back(e);
		sent[eg]++;
	endtask

	task automatic collect_beat(input int p, input logic [63:0] d, input logic [7:0] k,
		input logic l);
		exp_t  e;
		string name;
		name = $sformatf("tx%0d", p);
		if (phase_mode == 1) begin
			while (pending_count(p) > 0) begin
				e = oldest_expected(p);
				if (e.data == d && e.keep == k && e.last == l)
					break;
				e = take_expected(p); // skipped, must be a counted drop
				gaps[p]++;
			end
		end
		if (pending_count(p) == 0) begin
			$display("%s delivered a beat that was never sent to it", name);
			err_other++;
		end else begin
			e = take_expected(p);
			compare_value({name, " data"}, e.data, d);
			compare_value({name, " keep"}, 64'(e.keep), 64'(k));
			compare_value({name, " last"}, 64'(e.last), 64'(l));
			assert (cyc - int'(e.sent_cyc) >= `ETH_DELAY_CYCLES) else begin
				$display("[ERROR] %s latency: expected >= %0d, actual %0d", name,
					`ETH_DELAY_CYCLES, cyc - int'(e.sent_cyc));
				err_value++;
			end
			delivered[p]++;
		end
	endtask

	// settle, drain with tready high, then check conservation per port
	task automatic end_phase();
		int t;
		int p;
		int rise [2];
		repeat (`ETH_DELAY_CYCLES + 4) step();
		ready_mode = 0;
		t = 0;
		while ((tx0_tvalid || tx1_tvalid) && !run_aborted) begin
			step();
			t++;
			if (t > drain_timeout)
				abort_run("egress rings did not drain with tready held high");
		end
		if (run_aborted)
			return;
		rise[0] = int'(drop0_count) - drop_base[0];
		rise[1] = int'(drop1_count) - drop_base[1];
		for (p = 0; p < 2; p++) begin
			compare_value($sformatf("tx%0d delivered plus dropped", p), 64'(sent[p]),
				64'(delivered[p] + rise[p]));
			assert (gaps[p] <= rise[p]) else begin
				$display("[ERROR] tx%0d order gaps: expected <= %0d, actual %0d", p,
					rise[p], gaps[p]);
				err_value++;
			end
			last_rise[p] = rise[p];
		end
		if (phase_mode == 2)
			compare_value("tx1 burst beats drained", 64'(`ETH_EGRESS_DEPTH),
				64'(delivered[1]));
		q0.delete();
		q1.delete();
		sent         = '{0, 0};
		delivered    = '{0, 0};
		gaps         = '{0, 0};
		drop_base[0] = int'(drop0_count);
		drop_base[1] = int'(drop1_count);
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk156) begin
		if (!eth_rst) begin
			if (tx0_tvalid && tx0_tready)
				collect_beat(0, tx0_tdata, tx0_tkeep, tx0_tlast);
			if (tx1_tvalid && tx1_tready)
				collect_beat(1, tx1_tdata, tx1_tkeep, tx1_tlast);
		end
	end

	initial begin
		int          fd;
		int          n;
		int          t;
		int          rxp;
		int          last_i;
		int          idle;
		int          egress;
		int          m;
		int          e0;
		int          e1;
		bit          phase_open;
		string       line;
		logic [63:0] data_v;
		logic [7:0]  keep_v;
		fd         = 0;
		eth_rst    = 1'b1;
		rx0_tvalid = 1'b0;
		rx0_tdata  = '0;
		rx0_tkeep  = '0;
		rx0_tlast  = 1'b0;
		rx1_tvalid = 1'b0;
		rx1_tdata  = '0;
		rx1_tkeep  = '0;
		rx1_tlast  = 1'b0;
		tx0_tready = 1'b1;
		tx1_tready = 1'b1;
		sent       = '{0, 0};
		delivered  = '{0, 0};
		gaps       = '{0, 0};
		drop_base  = '{0, 0};
		last_rise  = '{0, 0};
		repeat (8) step();
		eth_rst = 1'b0;
		compare_value("reset tx0_tvalid", 64'd0, 64'(tx0_tvalid));
		compare_value("reset tx1_tvalid", 64'd0, 64'(tx1_tvalid));
		compare_value("reset drop0_count", 64'd0, 64'(drop0_count));
		compare_value("reset drop1_count", 64'd0, 64'(drop1_count));
		compare_value("reset delay_active", 64'd0, 64'(delay_active));
		t = 0;
		while (!delay_active && !run_aborted) begin
			step();
			t++;
			if (t > active_timeout)
				abort_run("delay_active never went high after reset");
		end
		if (!run_aborted) begin
			fd = $fopen("test/xc_stimulus.txt", "r");
			if (fd == 0)
				abort_run("could not open test/xc_stimulus.txt");
		end
		phase_open = 1'b0;
		while (fd != 0 && !run_aborted && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0) begin
				case (line.getc(0))
					"P": begin
						n = $sscanf(line, "P %d", m);
						if (phase_open)
							end_phase();
						phase_mode   = m;
						ready_mode   = m;
						drop_base[0] = int'(drop0_count);
						drop_base[1] = int'(drop1_count);
						phase_open   = 1'b1;
					end
					"B": begin
						n = $sscanf(line, "B %d %h %h %d %d %d", rxp, data_v, keep_v,
							last_i, idle, egress);
						if (n != 6) begin
							$display("could not parse beat record: %s", line);
							err_other++;
						end else begin
							send_beat(rxp, data_v, keep_v, last_i[0], egress);
							repeat (idle) step();
						end
					end
					"E": begin
						n = $sscanf(line, "E %d %d", e0, e1);
						if (phase_open)
							end_phase();
						phase_open = 1'b0;
						compare_value("drop0_count rise", 64'(e0), 64'(last_rise[0]));
						compare_value("drop1_count rise", 64'(e1), 64'(last_rise[1]));
					end
					default: ; // comments and blank lines
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (phase_open && !run_aborted)
			end_phase();
		final_report();
	end

endmodule

`default_nettype wire

/* logic/eth_xconnect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_xc_config.svh"

module eth_xconnect (
	input  logic                   clk156,
	input  logic                   eth_rst,

	// port 0
	input  logic                   rx0_tvalid,
	input  logic [`ETH_DATA_W-1:0] rx0_tdata,
	input  logic [`ETH_KEEP_W-1:0] rx0_tkeep,
	input  logic                   rx0_tlast,
	output logic                   tx0_tvalid,
	input  logic                   tx0_tready,
	output logic [`ETH_DATA_W-1:0] tx0_tdata,
	output logic [`ETH_KEEP_W-1:0] tx0_tkeep,
	output logic                   tx0_tlast,
	output logic [`ETH_DROP_W-1:0] drop0_count,

	// port 1
	input  logic                   rx1_tvalid,
	input  logic [`ETH_DATA_W-1:0] rx1_tdata,
	input  logic [`ETH_KEEP_W-1:0] rx1_tkeep,
	input  logic                   rx1_tlast,
	output logic                   tx1_tvalid,
	input  logic                   tx1_tready,
	output logic [`ETH_DATA_W-1:0] tx1_tdata,
	output logic [`ETH_KEEP_W-1:0] tx1_tkeep,
	output logic                   tx1_tlast,
	output logic [`ETH_DROP_W-1:0] drop1_count,

	output logic                   delay_active
);

	import eth_xc_pkg::*;

	slot_t rx0_slot;
	slot_t rx1_slot;
	logic  capture;
	logic  release_en;

	axis_beat_if tx0_if ();
	axis_beat_if tx1_if ();

	// valid bit leads, then data, keep, last
	assign rx0_slot = {rx0_tvalid, rx0_tdata, rx0_tkeep, rx0_tlast};
	assign rx1_slot = {rx1_tvalid, rx1_tdata, rx1_tkeep, rx1_tlast};

	latency_ctrl u_latency_ctrl (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.capture     (capture),
		.release_en  (release_en),
		.delay_active(delay_active)
	);

	// rx0 goes out on tx1
	delay_path u_path_0to1 (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx        (rx0_slot),
		.capture   (capture),
		.release_en(release_en),
		.tx        (tx1_if.src),
		.drop_count(drop1_count)
	);

	// rx1 goes out on tx0
	delay_path u_path_1to0 (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx        (rx1_slot),
		.capture   (capture),
		.release_en(release_en),
		.tx        (tx0_if.src),
		.drop_count(drop0_count)
	);

	assign tx0_tvalid    = tx0_if.tvalid;
	assign tx0_tdata     = tx0_if.tdata;
	assign tx0_tkeep     = tx0_if.tkeep;
	assign tx0_tlast     = tx0_if.tlast;
	assign tx0_if.tready = tx0_tready;

	assign tx1_tvalid    = tx1_if.tvalid;
	assign tx1_tdata     = tx1_if.tdata;
	assign tx1_tkeep     = tx1_if.tkeep;
	assign tx1_tlast     = tx1_if.tlast;
	assign tx1_if.tready = tx1_tready;

endmodule

`default_nettype wire

/* logic/delay_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_xc_config.svh"

module delay_path (
	input  logic                   clk156,
	input  logic                   eth_rst,
	input  eth_xc_pkg::slot_t      rx,
	input  logic                   capture,
	input  logic                   release_en,
	axis_beat_if.src               tx,
	output logic [`ETH_DROP_W-1:0] drop_count
);

	import eth_xc_pkg::*;

	slot_t dly_head;  // slot leaving the delay line this cycle
	logic  dly_empty;

	beat_t eg_head;
	logic  eg_full;
	logic  eg_empty;

	logic rel_valid; // released slot carries a beat
	logic eg_pop;
	logic drop;

	// every cycle is sampled, idle ones included, to keep beat spacing
	sample_ring #(
		.payload_t (slot_t),
		.depth     (`ETH_DELAY_DEPTH)
	) u_delay_ring (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.push   (capture),
		.wdata  (rx),
		.pop    (release_en),
		.rdata  (dly_head),
		.full   (),
		.empty  (dly_empty)
	);

	assign rel_valid = release_en && !dly_empty && dly_head.valid;
	assign eg_pop    = tx.tvalid && tx.tready;
	assign drop      = rel_valid && eg_full && !eg_pop; // no room this cycle

	sample_ring #(
		.payload_t (beat_t),
		.depth     (`ETH_EGRESS_DEPTH)
	) u_egress_ring (
		.clk156 (clk156),
		.eth_rst(eth_rst),
		.push   (rel_valid),
		.wdata  (dly_head.beat),
		.pop    (eg_pop),
		.rdata  (eg_head),
		.full   (eg_full),
		.empty  (eg_empty)
	);

	// tx is the egress head, held until the handshake
	assign tx.tvalid = !eg_empty;
	assign tx.tdata  = eg_head.data;
	assign tx.tkeep  = eg_head.keep;
	assign tx.tlast  = eg_head.last;

	always_ff @(posedge clk156) begin
		if (eth_rst)
			drop_count <= '0;
		else if (drop && (drop_count != '1))
			drop_count <= drop_count + 1'b1; // saturates at all ones
	end

endmodule

`default_nettype wire

/* logic/sample_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_ring #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
) (
	input  logic     clk156,
	input  logic     eth_rst,
	input  logic     push,
	input  payload_t wdata,
	input  logic     pop,
	output payload_t rdata,
	output logic     full,
	output logic     empty
);

	localparam int addr_w = $clog2(depth);
	localparam int cnt_w  = $clog2(depth + 1);

	payload_t          mem [depth];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [cnt_w-1:0]  count;

	logic wr_en;
	logic rd_en;

	assign rd_en = pop && !empty;
	// a pop in the same cycle frees the slot for the push
	assign wr_en = push && (!full || rd_en);

	always_ff @(posedge clk156) begin
		if (wr_en)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			unique case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or push and pop together
			endcase
		end
	end

	// show-ahead head, valid whenever not empty
	assign rdata = mem[rd_ptr];
	assign full  = (count == cnt_w'(depth));
	assign empty = (count == '0);

endmodule

`default_nettype wire

/* logic/latency_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_xc_config.svh"

module latency_ctrl (
	input  logic clk156,
	input  logic eth_rst,
	output logic capture,
	output logic release_en,
	output logic delay_active
);

	import eth_xc_pkg::*;

	localparam int cnt_w = $clog2(`ETH_DELAY_CYCLES) + 1;

	xc_state_t          state;
	logic [cnt_w-1:0]   wait_cnt; // cycles spent in FILL

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state    <= IDLE;
			wait_cnt <= '0;
		end else begin
			unique case (state)
				IDLE: state <= FILL;
				FILL: begin
					if (wait_cnt == cnt_w'(`ETH_DELAY_CYCLES - 1))
						state <= RELEASE; // ring now holds the full delay
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				RELEASE: state <= RELEASE; // stays until reset
				default: state <= IDLE;
			endcase
		end
	end

	// both directions share one capture and release schedule
	assign capture      = (state == FILL) || (state == RELEASE);
	assign release_en   = (state == RELEASE);
	assign delay_active = (state == RELEASE);

endmodule

`default_nettype wire

/* logic/axis_beat_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_xc_config.svh"

interface axis_beat_if;

	logic                   tvalid;
	logic                   tready;
	logic [`ETH_DATA_W-1:0] tdata;
	logic [`ETH_KEEP_W-1:0] tkeep;
	logic                   tlast;

	modport src (
		output tvalid,
		input  tready,
		output tdata,
		output tkeep,
		output tlast
	);

	modport snk (
		input  tvalid,
		output tready,
		input  tdata,
		input  tkeep,
		input  tlast
	);

endinterface

`default_nettype wire

/* logic/eth_xc_pkg.sv */
`default_nettype none

`include "eth_xc_config.svh"

package eth_xc_pkg;

	// one stream beat, 73 bits with the default widths
	typedef struct packed {
		logic [`ETH_DATA_W-1:0] data;
		logic [`ETH_KEEP_W-1:0] keep;
		logic                   last;
	} beat_t;

	// one sampled rx cycle, idle cycles carry valid low
	typedef struct packed {
		logic  valid;
		beat_t beat;
	} slot_t;

	// latency controller sequence
	typedef enum logic [1:0] {
		IDLE    = 2'd0, // held in reset
		FILL    = 2'd1, // capturing, nothing released yet
		RELEASE = 2'd2  // steady state
	} xc_state_t;

endpackage

`default_nettype wire

/* include/eth_xc_config.svh */
`ifndef ETH_XC_CONFIG_SVH
`define ETH_XC_CONFIG_SVH

// beat payload of the 10G stream
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// emulated link latency in clk156 cycles
`define ETH_DELAY_CYCLES 16

// delay ring holds one slot per cycle of latency, so it
// has to be deeper than ETH_DELAY_CYCLES
`define ETH_DELAY_DEPTH 32

// beats held while the tx side is stalled
`define ETH_EGRESS_DEPTH 8

// saturating drop counter
`define ETH_DROP_W 16

`endif
